// ==== sl_consts.svh ====
`ifndef SL_CONSTS_SVH
`define SL_CONSTS_SVH

//////////////////////////////////////////////////
// geometry
//////////////////////////////////////////////////
`define SL_PIX_W       8            // fringe value per pixel
`define SL_LUT_AW      10
`define SL_LUT_DEPTH   1024
`define SL_PHASE_W     32           // accumulator width
`define SL_CNT_W       16           // sync level counters

//////////////////////////////////////////////////
// phase-shift sequence
//////////////////////////////////////////////////
`define SL_FRAME_W     6
`define SL_FRAMES      6'd48        // full sequence
`define SL_ROW_FRAMES  6'd24        // first column frame
`define SL_STEPS       6'd8         // shifts per frequency

// row stripe increments, low to high frequency
`define SL_INC_H1      32'd5965232
`define SL_INC_H2      32'd35791394
`define SL_INC_H3      32'd178956971
// column stripe increments
`define SL_INC_V1      32'd4473924
`define SL_INC_V2      32'd26843546
`define SL_INC_V3      32'd134217728

`define SL_PHASE_BASE  32'd357913941   // trims the fringe ends
`define SL_PHASE_STEP  32'd536870912   // 2^32 / 8

`endif

// ==== video_pkg.sv ====
`include "sl_consts.svh"

package video_pkg;

  // sync decision helpers

  // the pulse is the shorter of the two levels
  // equal lengths count as active low
  function automatic logic sync_active_high(
    input logic [`SL_CNT_W-1:0] len_hi,
    input logic [`SL_CNT_W-1:0] len_lo
  );
    logic shorter_hi;
    shorter_hi = (len_hi < len_lo);
    return shorter_hi;
  endfunction

endpackage

// ==== pattern_pkg.sv ====
`include "sl_consts.svh"

package pattern_pkg;

  // one phase word, two readings
  typedef union packed {
    logic [`SL_PHASE_W-1:0] raw;                  // what the accumulator adds to
    struct packed {
      logic [`SL_LUT_AW-1:0]             idx;     // table entry
      logic [`SL_PHASE_W-`SL_LUT_AW-1:0] frac;    // sub-entry phase, dropped
    } fld;
  } phase_word_u;

  // per-frame increment, row set below frame 24, column set above
  function automatic logic [`SL_PHASE_W-1:0] frame_increment(
    input logic [`SL_FRAME_W-1:0] f
  );
    logic                   col;
    logic [`SL_FRAME_W-1:0] g;
    logic [`SL_FRAME_W-1:0] k;
    logic [`SL_PHASE_W-1:0] inc;
    col = (f >= `SL_ROW_FRAMES);
    g   = col ? (f - `SL_ROW_FRAMES) : f;   // position inside orientation
    k   = g / `SL_STEPS;                    // frequency 0..2
    case (k)
      0:       inc = col ? `SL_INC_V1 : `SL_INC_H1;
      1:       inc = col ? `SL_INC_V2 : `SL_INC_H2;
      default: inc = col ? `SL_INC_V3 : `SL_INC_H3;
    endcase
    return inc;
  endfunction

  // base plus n eighths of a turn, wraps mod 2^32
  function automatic logic [`SL_PHASE_W-1:0] frame_offset(
    input logic [`SL_FRAME_W-1:0] f
  );
    logic [`SL_FRAME_W-1:0] n;
    n = f % `SL_STEPS;
    return `SL_PHASE_BASE + n * `SL_PHASE_STEP;
  endfunction

endpackage

// ==== sync_polarity.sv ====
`include "sl_consts.svh"

module sync_polarity (
  input  logic rx0_pllclk1,
  input  logic new_tx_data,
  input  logic hs_in_i,
  input  logic vs_in_i,
  input  logic de_i,
  output logic hs_act_o,
  output logic vs_act_o,
  output logic de_o
);
  import video_pkg::*;

  logic [1:0] sync_in;    // {vsync, hsync} as received
  logic [1:0] sync_q;     // previous sample
  logic [1:0] cnt_en;     // what a level is measured in
  logic [1:0] inv;        // flip to active high
  logic       hs_rise;

  assign sync_in = {vs_in_i, hs_in_i};
  assign hs_rise = hs_in_i & ~sync_q[0];
  assign cnt_en  = {hs_rise, 1'b1};   // vsync in lines, hsync in pixels

  //////////////////////////////////////////////////
  // level length measurement, one lane per sync
  //////////////////////////////////////////////////
  for (genvar i = 0; i < 2; i++)
  begin : g_meas
    logic [`SL_CNT_W-1:0] cnt;
    logic [`SL_CNT_W-1:0] len_hi;
    logic [`SL_CNT_W-1:0] len_lo;
    logic                 started;   // first edge seen, levels now complete
    logic                 seen_hi;
    logic                 seen_lo;

    always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
    begin
      if (new_tx_data)
      begin
        cnt     <= '0;
        len_hi  <= '0;
        len_lo  <= '0;
        started <= 1'b0;
        seen_hi <= 1'b0;
        seen_lo <= 1'b0;
      end
      else if (sync_in[i] != sync_q[i])
      begin
        cnt     <= '0;               // new level
        started <= 1'b1;
        if (started && sync_q[i])
        begin
          len_hi  <= cnt;            // high level just ended
          seen_hi <= 1'b1;
        end
        else if (started)
        begin
          len_lo  <= cnt;
          seen_lo <= 1'b1;
        end
      end
      else if (cnt_en[i] && (cnt != '1))
        cnt <= cnt + 1'b1;           // saturates on a stuck sync
    end

    // active high until both levels measured
    assign inv[i] = seen_hi & seen_lo & ~sync_active_high(len_hi, len_lo);
  end

  // normalized syncs, registered with de
  always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      sync_q   <= '0;
      hs_act_o <= 1'b0;
      vs_act_o <= 1'b0;
      de_o     <= 1'b0;
    end
    else
    begin
      sync_q   <= sync_in;
      hs_act_o <= hs_in_i ^ inv[0];
      vs_act_o <= vs_in_i ^ inv[1];
      de_o     <= de_i;
    end
  end

endmodule

// ==== frame_sequencer.sv ====
`include "sl_consts.svh"

module frame_sequencer (
  input  logic                   rx0_pllclk1,
  input  logic                   new_tx_data,
  input  logic                   vs_act_i,
  input  logic                   seq_en_i,
  output logic [`SL_PHASE_W-1:0] phase_inc_o,
  output logic [`SL_PHASE_W-1:0] phase_off_o,
  output logic                   col_mode_o,
  output logic                   cam_trig_o
);
  import pattern_pkg::*;

  logic [`SL_FRAME_W-1:0] frame_cur;   // frame being shown
  logic [`SL_FRAME_W-1:0] frame_nxt;   // frame after next vsync
  logic                   vs_q;
  logic                   vs_rise;

  assign vs_rise = vs_act_i & ~vs_q;

  //////////////////////////////////////////////////
  // frame stepping and camera trigger
  //////////////////////////////////////////////////
  always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      vs_q       <= 1'b0;
      cam_trig_o <= 1'b0;
      frame_cur  <= '0;
      frame_nxt  <= '0;
    end
    else
    begin
      vs_q       <= vs_act_i;
      cam_trig_o <= vs_rise & seq_en_i;   // one pulse per frame
      if (!seq_en_i)
      begin
        frame_cur <= '0;                  // disarmed, restart at 0
        frame_nxt <= '0;
      end
      else if (vs_rise)
      begin
        frame_cur <= frame_nxt;
        if (frame_nxt == `SL_FRAMES - 1'b1)
          frame_nxt <= '0;                // wrap after 47
        else
          frame_nxt <= frame_nxt + 1'b1;
      end
    end
  end

  // steady for the whole frame, changes only at vsync
  assign phase_inc_o = frame_increment(frame_cur);
  assign phase_off_o = frame_offset(frame_cur);
  assign col_mode_o  = (frame_cur >= `SL_ROW_FRAMES);   // column stripes

endmodule

// ==== phase_dds.sv ====
`include "sl_consts.svh"

module phase_dds (
  input  logic                   rx0_pllclk1,
  input  logic                   new_tx_data,
  input  logic                   hs_act_i,
  input  logic                   vs_act_i,
  input  logic                   de_i,
  input  logic                   col_mode_i,
  input  logic [`SL_PHASE_W-1:0] phase_inc_i,
  input  logic [`SL_PHASE_W-1:0] phase_off_i,
  output logic                   rd_en_o,
  output logic [`SL_LUT_AW-1:0]  rd_idx_o
);
  import pattern_pkg::*;

  phase_word_u row_acc;    // steps once per line
  phase_word_u col_acc;    // steps once per pixel
  logic        hs_q;
  logic        hs_rise;

  assign hs_rise = hs_act_i & ~hs_q;

  //////////////////////////////////////////////////
  // phase accumulators
  //////////////////////////////////////////////////
  always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      hs_q        <= 1'b0;
      rd_en_o     <= 1'b0;
      row_acc.raw <= '0;
      col_acc.raw <= '0;
    end
    else
    begin
      hs_q    <= hs_act_i;
      rd_en_o <= de_i;                               // one read per de pixel
      // row stripes, reloaded from vsync rise through the pulse
      if (vs_act_i)
        row_acc.raw <= phase_off_i;
      else if (hs_rise)
        row_acc.raw <= row_acc.raw + phase_inc_i;
      // column stripes, reloaded each hsync
      if (hs_act_i)
        col_acc.raw <= phase_off_i;
      else if (de_i)
        col_acc.raw <= col_acc.raw + phase_inc_i;    // after this pixel
    end
  end

  // table index, sampled before the pixel's own add
  always_ff @(posedge rx0_pllclk1)
  begin
    if (de_i)
    begin
      if (col_mode_i)
        rd_idx_o <= col_acc.fld.idx;
      else
        rd_idx_o <= row_acc.fld.idx;
    end
  end

endmodule

// ==== lut_arbiter.sv ====
`include "sl_consts.svh"

module lut_arbiter (
  input  logic                  rx0_pllclk1,
  input  logic                  new_tx_data,
  input  logic                  rd_en_i,
  input  logic [`SL_LUT_AW-1:0] rd_idx_i,
  output logic [`SL_PIX_W-1:0]  rd_data_o,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`SL_LUT_AW-1:0] wb_adr_i,
  input  logic [`SL_PIX_W-1:0]  wb_dat_i,
  output logic [`SL_PIX_W-1:0]  wb_dat_o,
  output logic                  wb_ack_o
);

  logic [`SL_PIX_W-1:0]  mem [0:`SL_LUT_DEPTH-1];   // fringe table
  logic [`SL_PIX_W-1:0]  q;                          // shared read register
  logic                  wb_req;
  logic                  wb_gnt;
  logic                  wr;
  logic [`SL_LUT_AW-1:0] addr;

  //////////////////////////////////////////////////
  // arbitration, pixel port always wins
  //////////////////////////////////////////////////

  // held strobe not yet acked counts as pending
  assign wb_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;
  assign wb_gnt = wb_req & ~rd_en_i;        // blanking only
  assign wr     = wb_gnt & wb_we_i;
  assign addr   = rd_en_i ? rd_idx_i : wb_adr_i;

  // single port, one access per cycle
  always_ff @(posedge rx0_pllclk1)
  begin
    if (wr)
      mem[addr] <= wb_dat_i;
    q <= mem[addr];                         // read-before-write
  end

  // ack one cycle after service
  always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
  begin
    if (new_tx_data)
      wb_ack_o <= 1'b0;
    else
      wb_ack_o <= wb_gnt;
  end

  assign rd_data_o = q;   // valid the cycle after a pixel read
  assign wb_dat_o  = q;   // valid with wb_ack_o

endmodule

// ==== sl_top.sv ====
`include "sl_consts.svh"

module sl_top (
  input  logic                  rx0_pllclk1,
  input  logic                  new_tx_data,
  input  logic                  hs_in_i,
  input  logic                  vs_in_i,
  input  logic                  de_i,
  input  logic                  seq_en_i,
  input  logic                  wb_cyc_i,
  input  logic                  wb_stb_i,
  input  logic                  wb_we_i,
  input  logic [`SL_LUT_AW-1:0] wb_adr_i,
  input  logic [`SL_PIX_W-1:0]  wb_dat_i,
  output logic [`SL_PIX_W-1:0]  wb_dat_o,
  output logic                  wb_ack_o,
  output logic [`SL_PIX_W-1:0]  pix_o,
  output logic                  hs_o,
  output logic                  vs_o,
  output logic                  de_o,
  output logic                  cam_trig_o
);

  logic                   hs_act;      // active-high syncs, t+1
  logic                   vs_act;
  logic                   de_s;
  logic [`SL_PHASE_W-1:0] phase_inc;
  logic [`SL_PHASE_W-1:0] phase_off;
  logic                   col_mode;
  logic                   rd_en;       // t+2
  logic [`SL_LUT_AW-1:0]  rd_idx;
  logic [2:0]             de_pipe;     // raw de to t+3
  logic [1:0]             hs_pipe;     // t+1 to t+3
  logic [1:0]             vs_pipe;

  sync_polarity u_sync (.rx0_pllclk1, .new_tx_data, .hs_in_i, .vs_in_i, .de_i,
    .hs_act_o(hs_act), .vs_act_o(vs_act), .de_o(de_s));

  frame_sequencer u_seq (.rx0_pllclk1, .new_tx_data, .vs_act_i(vs_act), .seq_en_i,
    .phase_inc_o(phase_inc), .phase_off_o(phase_off), .col_mode_o(col_mode),
    .cam_trig_o);

  phase_dds u_dds (.rx0_pllclk1, .new_tx_data, .hs_act_i(hs_act), .vs_act_i(vs_act),
    .de_i(de_s), .col_mode_i(col_mode), .phase_inc_i(phase_inc), .phase_off_i(phase_off),
    .rd_en_o(rd_en), .rd_idx_o(rd_idx));

  lut_arbiter u_lut (.rx0_pllclk1, .new_tx_data, .rd_en_i(rd_en), .rd_idx_i(rd_idx),
    .rd_data_o(pix_o), .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
    .wb_dat_o, .wb_ack_o);

  //////////////////////////////////////////////////
  // output alignment to the pixel at t+3
  //////////////////////////////////////////////////
  always_ff @(posedge rx0_pllclk1 or posedge new_tx_data)
  begin
    if (new_tx_data)
    begin
      de_pipe <= '0;
      hs_pipe <= '0;
      vs_pipe <= '0;
    end
    else
    begin
      de_pipe <= {de_pipe[1:0], de_i};
      hs_pipe <= {hs_pipe[0], hs_act};
      vs_pipe <= {vs_pipe[0], vs_act};
    end
  end

  assign de_o = de_pipe[2];
  assign hs_o = hs_pipe[1];
  assign vs_o = vs_pipe[1];

endmodule

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD  = 40,
  parameter int RST_CYC = 8
) (
  output logic clk_o,
  output logic rst_o
);
  timeunit 1ns;
  timeprecision 100ps;

  initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;                  // held from time 0
    repeat (RST_CYC) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

  always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

// ==== sl_sva.sv ====
`include "sl_consts.svh"

module sl_sva (
  input logic rx0_pllclk1,
  input logic new_tx_data,
  input logic rd_en_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack lasts one cycle only
  ack_single_cycle: assert property (@(posedge rx0_pllclk1) disable iff (new_tx_data)
    wb_ack_o |=> !wb_ack_o)
    else $error("wb_ack_o held for more than one cycle");

  // ack only answers a strobe seen in the cycle before
  ack_needs_request: assert property (@(posedge rx0_pllclk1) disable iff (new_tx_data)
    wb_ack_o |-> $past(wb_cyc_i & wb_stb_i))
    else $error("wb_ack_o without a pending request");

  // a pixel read cycle never serves the host
  pixel_priority: assert property (@(posedge rx0_pllclk1) disable iff (new_tx_data)
    $past(rd_en_i) |-> !wb_ack_o)
    else $error("host served during a pixel read");

endmodule

bind lut_arbiter sl_sva u_sva (.*);

// ==== sl_tb.sv ====
`include "sl_consts.svh"

module sl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int LINE_CYC  = 22;                 // 2 sync, 2 porch, 16 de, 2 porch
  localparam int FRAME_LN  = 6;                  // 2 vsync lines, 4 active
  localparam int N_FRAMES  = 79;
  localparam int LIMIT     = 2 * (N_FRAMES * LINE_CYC * FRAME_LN + 1024 * 3 + 400);

  logic       clk;
  logic       rst;
  logic       hs_in_i, vs_in_i, de_i, seq_en_i;
  logic       wb_cyc_i, wb_stb_i, wb_we_i;
  logic [9:0] wb_adr_i;
  logic [7:0] wb_dat_i, wb_dat_o, pix_o;
  logic       wb_ack_o, hs_o, vs_o, de_o, cam_trig_o;

  logic [7:0]  tbl [0:1023];       // host view of the fringe table
  logic [31:0] lfsr;
  logic        sync_low;           // source drives active-low syncs
  logic        chk_sync;
  int          shown, nxt;         // frame model
  int          trig_exp, trig_seen;
  int          cyc_cnt;
  int          err_cnt;
  // expectation pipe where index 2 is three cycles old
  logic       h_de [0:2];
  logic       h_hs [0:2];
  logic       h_vs [0:2];
  logic       h_cp [0:2];
  logic       h_cs [0:2];
  logic [7:0] h_px [0:2];

  tb_clock_gen #(.PERIOD(40), .RST_CYC(8)) u_clk (.clk_o(clk), .rst_o(rst));

  sl_top DUT (
    .rx0_pllclk1(clk), .new_tx_data(rst), .hs_in_i, .vs_in_i, .de_i, .seq_en_i,
    .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i, .wb_dat_o, .wb_ack_o,
    .pix_o, .hs_o, .vs_o, .de_o, .cam_trig_o);

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////
  task automatic fail_now(input string msg);
    err_cnt++;
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      err_cnt++;
      $display("MISMATCH %s got %h expected %h", name, got, exp);
      $display("Simulation failed");
      $fatal(1);
    end
  endtask

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic rand_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++)
    begin
      b    = {b[6:0], lfsr[31]};
      lfsr = lfsr_next(lfsr);     // one step per bit
    end
  endtask

  // fringe value from frame index and step count
  function automatic logic [7:0] exp_pix(input int f, input int n);
    int          k;
    logic [31:0] inc, off, ph;
    k = (f % 24) / 8;
    if (f < 24)
      inc = (k == 0) ? `SL_INC_H1 : (k == 1) ? `SL_INC_H2 : `SL_INC_H3;
    else
      inc = (k == 0) ? `SL_INC_V1 : (k == 1) ? `SL_INC_V2 : `SL_INC_V3;
    off = 32'd357913941 + 32'(f % 8) * 32'h2000_0000;   // base plus eighth turns
    ph  = off + 32'(n) * inc;
    return tbl[ph[31:22]];
  endfunction

  // one pixel clock that checks the t-3 entry then drives
  task automatic step(input logic hs, input logic vs, input logic de,
                      input logic cp, input logic [7:0] px);
    @(negedge clk);
    check_val("de_o", de_o, h_de[2]);
    if (h_cs[2])
    begin
      check_val("hs_o", hs_o, h_hs[2]);
      check_val("vs_o", vs_o, h_vs[2]);
    end
    if (h_cp[2] && h_de[2])
      check_val("pix_o", pix_o, h_px[2]);
    if (cam_trig_o)
      trig_seen++;
    for (int i = 2; i > 0; i--)
    begin
      h_de[i] = h_de[i-1];
      h_hs[i] = h_hs[i-1];
      h_vs[i] = h_vs[i-1];
      h_cp[i] = h_cp[i-1];
      h_cs[i] = h_cs[i-1];
      h_px[i] = h_px[i-1];
    end
    h_de[0] = de;
    h_hs[0] = hs;
    h_vs[0] = vs;
    h_cp[0] = cp;
    h_cs[0] = chk_sync;
    h_px[0] = px;
    hs_in_i = hs ^ sync_low;    // source polarity
    vs_in_i = vs ^ sync_low;
    de_i    = de;
  endtask

  task automatic idle_steps(input int n);
    repeat (n) step(1'b0, 1'b0, 1'b0, 1'b0, 8'h00);
  endtask

  // one frame with the vsync lines first
  task automatic run_frame(input logic cp);
    logic       hs, vs, de;
    logic [7:0] px;
    for (int l = 0; l < FRAME_LN; l++)
    begin
      for (int c = 0; c < LINE_CYC; c++)
      begin
        if (l == 0 && c == 0 && seq_en_i)
        begin
          shown = nxt;            // advance at vsync
          nxt   = (nxt + 1) % 48;
          trig_exp++;
        end
        hs = (c < 2);
        vs = (l < 2);
        de = (l >= 2) && (c >= 4) && (c < 20);
        px = (shown >= 24) ? exp_pix(shown, c - 4) : exp_pix(shown, l - 1);
        step(hs, vs, de, cp, px);
      end
    end
    check_val("cam_trig_o count", trig_seen, trig_exp);   // one pulse per armed frame
  endtask

  task automatic wb_access(input logic we, input logic [9:0] adr, input logic [7:0] dat,
                           output logic [7:0] rdat);
    logic got;
    got      = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = dat;
    for (int i = 0; i < 50 && !got; i++)
    begin
      @(negedge clk);
      got = wb_ack_o;
    end
    if (!got)
      fail_now("wishbone access was never acknowledged");
    rdat     = wb_dat_o;
    wb_cyc_i = 1'b0;               // drop after the ack
    wb_stb_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////
  task automatic test_reset;
    check_val("wb_ack_o", wb_ack_o, 0);
    check_val("cam_trig_o", cam_trig_o, 0);
    check_val("de_o", de_o, 0);
    check_val("hs_o", hs_o, 0);
    check_val("vs_o", vs_o, 0);
  endtask

  task automatic test_table;
    logic [7:0] b, r;
    logic       got;
    for (int a = 0; a < 1024; a++)
    begin
      rand_byte(b);
      tbl[a] = b;
      wb_access(1'b1, 10'(a), b, r);
    end
    for (int a = 5; a < 1024; a += 37)
    begin
      wb_access(1'b0, 10'(a), 8'h00, r);
      check_val("wb_dat_o", r, tbl[a]);
    end
    // host read held off by active video
    repeat (3) step(1'b0, 1'b0, 1'b1, 1'b0, 8'h00);
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = 1'b0;
    wb_adr_i = 10'd777;
    repeat (8)
    begin
      step(1'b0, 1'b0, 1'b1, 1'b0, 8'h00);
      check_val("wb_ack_o", wb_ack_o, 0);
    end
    got = 1'b0;
    for (int i = 0; i < 10 && !got; i++)
    begin
      step(1'b0, 1'b0, 1'b0, 1'b0, 8'h00);
      got = wb_ack_o;
    end
    if (!got)
      fail_now("blocked host read not acknowledged after de went low");
    check_val("wb_dat_o", wb_dat_o, tbl[777]);
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    idle_steps(4);
  endtask

  task automatic test_polarity;
    sync_low = 1'b1;
    idle_steps(4);
    run_frame(1'b0);               // measuring
    run_frame(1'b0);
    chk_sync = 1'b1;
    run_frame(1'b1);
  endtask

  task automatic test_rows;
    seq_en_i = 1'b1;
    run_frame(1'b1);               // frame 0
  endtask

  task automatic test_columns;
    repeat (25) run_frame(1'b1);   // through 24 and 25
    idle_steps(4);
    check_val("cam_trig count", trig_seen, trig_exp);
  endtask

  task automatic test_trigger;
    seq_en_i = 1'b0;
    shown    = 0;                  // disarm resets the sequence
    nxt      = 0;
    run_frame(1'b1);
    seq_en_i = 1'b1;
    repeat (49) run_frame(1'b1);   // wraps after 47
    idle_steps(4);
    check_val("cam_trig count", trig_seen, trig_exp);
  endtask

  // run limit
  always @(posedge clk)
  begin
    cyc_cnt++;
    if (cyc_cnt > LIMIT)
    begin
      $display("timeout, the tests did not finish in time");
      $display("Simulation failed");
      $fatal(1);
    end
  end

  initial
  begin
    hs_in_i   = 1'b0;
    vs_in_i   = 1'b0;
    de_i      = 1'b0;
    seq_en_i  = 1'b0;
    wb_cyc_i  = 1'b0;
    wb_stb_i  = 1'b0;
    wb_we_i   = 1'b0;
    wb_adr_i  = '0;
    wb_dat_i  = '0;
    lfsr      = 32'h70c9;
    sync_low  = 1'b0;
    chk_sync  = 1'b0;
    shown     = 0;
    nxt       = 0;
    trig_exp  = 0;
    trig_seen = 0;
    cyc_cnt   = 0;
    err_cnt   = 0;
    for (int i = 0; i < 3; i++)
    begin
      h_de[i] = 1'b0;
      h_hs[i] = 1'b0;
      h_vs[i] = 1'b0;
      h_cp[i] = 1'b0;
      h_cs[i] = 1'b0;
      h_px[i] = '0;
    end
    @(negedge rst);
    test_reset();
    test_table();
    test_polarity();
    test_rows();
    test_columns();
    test_trigger();
    if (err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== sim.f ====
+incdir+.
video_pkg.sv
pattern_pkg.sv
sync_polarity.sv
frame_sequencer.sv
phase_dds.sv
lut_arbiter.sv
sl_top.sv
tb_clock_gen.sv
sl_sva.sv
sl_tb.sv
